//--- verilog/muldiv_pkg.sv
// shared types for the rv32m multiply/divide unit
// data words, op encodings, fsm states, request and write-back records

package muldiv_pkg;

    typedef logic [31:0] reg_data_t;   // register data word
    typedef logic [4:0]  reg_addr_t;   // destination register index
    typedef logic [2:0]  md_funct3_t;  // funct3 of an m-extension instruction

    // funct3 bit 2 splits multiply from divide
    localparam int unsigned FUNCT3_DIV_BIT = 2;

    // values follow funct3[1:0] of mul/mulh/mulhsu/mulhu
    typedef enum logic [1:0] {
        MUL_LO  = 2'd0,
        MUL_HSS = 2'd1,
        MUL_HSU = 2'd2,
        MUL_HUU = 2'd3
    } mul_op_t;

    // values follow funct3[1:0] of div/divu/rem/remu
    typedef enum logic [1:0] {
        DIV_S = 2'd0,
        DIV_U = 2'd1,
        REM_S = 2'd2,
        REM_U = 2'd3
    } div_op_t;

    typedef enum logic [1:0] {
        M_IDLE   = 2'b00,
        M_CALC   = 2'b01,
        M_OUTPUT = 2'b10
    } mul_state_t;

    typedef enum logic [1:0] {
        D_IDLE   = 2'b00,
        D_CALC   = 2'b01,
        D_OUTPUT = 2'b10
    } div_state_t;

    typedef struct packed {
        md_funct3_t funct3;
        reg_data_t  rs1;
        reg_data_t  rs2;
        reg_addr_t  rd;
    } md_req_t;

    typedef struct packed {
        reg_data_t data;
        reg_addr_t rd;
    } md_wb_t;

endpackage

//--- verilog/exu_mul.sv
`timescale 1ns/1ns
// radix-4 booth multiplier, 16 iterations
// signed core with upper-half correction for mulhsu and mulhu

module exu_mul
    import muldiv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_data_t multiplicand_i,  // rs1
    input  reg_data_t multiplier_i,    // rs2
    input  logic      start_i,         // held high for the whole operation
    input  mul_op_t   op_i,
    input  reg_addr_t reg_waddr_i,
    output reg_data_t result_o,
    output logic      ready_o,         // one-cycle pulse
    output logic      busy_o,
    output reg_addr_t reg_waddr_o
);

    typedef logic [66:0] booth_t;  // two data words plus guard bits

    mul_state_t  state;
    mul_state_t  state_nxt;
    logic [3:0]  count;            // booth step counter
    mul_op_t     op_r;
    reg_data_t   multiplicand_r;
    reg_data_t   multiplier_r;
    reg_addr_t   reg_waddr_r;

    logic [33:0] mcand_ext;        // sign extended by two bits
    logic [33:0] mcand_x2;
    booth_t      add1;
    booth_t      sub1;
    booth_t      add_x2;
    booth_t      sub_x2;
    booth_t      p_reg;            // accumulator and multiplier bits
    booth_t      booth_sum;

    reg_data_t   prod_hi;
    reg_data_t   prod_lo;
    reg_data_t   add_mul;
    reg_data_t   add_mcand;

    assign mcand_ext = {{2{multiplicand_i[31]}}, multiplicand_i};
    assign mcand_x2  = {multiplicand_i[31], multiplicand_i, 1'b0};

    assign prod_hi = p_reg[64:33];
    assign prod_lo = p_reg[32:1];

    // rs1 top bit read as sign by the core, add rs2 back
    assign add_mul   = multiplicand_r[31] ? multiplier_r : '0;
    // rs2 top bit read as sign, add rs1 back
    assign add_mcand = multiplier_r[31] ? multiplicand_r : '0;

    // one booth step, decoded from the three low bits
    always_comb begin
        case (p_reg[2:0])
            3'b001, 3'b010: booth_sum = p_reg + add1;
            3'b101, 3'b110: booth_sum = p_reg + sub1;
            3'b011:         booth_sum = p_reg + add_x2;
            3'b100:         booth_sum = p_reg + sub_x2;
            default:        booth_sum = p_reg;  // 000 and 111
        endcase
    end

    always_comb begin
        case (state)
            M_IDLE:   state_nxt = M_CALC;
            M_CALC:   state_nxt = (count == 4'd15) ? M_OUTPUT : M_CALC;
            M_OUTPUT: state_nxt = M_IDLE;
            default:  state_nxt = M_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= M_IDLE;
        end else if (!start_i) begin
            state <= M_IDLE;  // dropped start aborts
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ready_o <= 1'b0;
            busy_o  <= 1'b0;
            count   <= '0;
        end else if (!start_i) begin
            ready_o <= 1'b0;
            busy_o  <= 1'b0;
        end else begin
            case (state)
                M_IDLE: begin
                    ready_o <= 1'b0;
                    busy_o  <= 1'b1;
                    count   <= '0;
                end
                M_CALC: count <= count + 4'd1;
                M_OUTPUT: begin
                    ready_o <= 1'b1;
                    busy_o  <= 1'b0;
                end
                default: ready_o <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            case (state)
                M_IDLE: begin
                    multiplicand_r <= multiplicand_i;
                    multiplier_r   <= multiplier_i;
                    op_r           <= op_i;
                    reg_waddr_r    <= reg_waddr_i;
                    add1           <= {mcand_ext, 33'b0};
                    sub1           <= {-mcand_ext, 33'b0};
                    add_x2         <= {mcand_x2, 33'b0};
                    sub_x2         <= {-mcand_x2, 33'b0};
                    p_reg          <= {34'b0, multiplier_i, 1'b0};
                end
                M_CALC: begin
                    p_reg <= {{2{booth_sum[66]}}, booth_sum[66:2]};  // asr by two
                end
                M_OUTPUT: begin
                    case (op_r)
                        MUL_LO:  result_o <= prod_lo;
                        MUL_HSS: result_o <= prod_hi;
                        MUL_HSU: result_o <= prod_hi + add_mcand;
                        MUL_HUU: result_o <= prod_hi + add_mul + add_mcand;
                        default: result_o <= prod_lo;
                    endcase
                    reg_waddr_o <= reg_waddr_r;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/exu_div.sv
`timescale 1ns/1ns
// radix-2 restoring divider, 32 iterations
// sign handling and risc-v divide-by-zero and overflow results

module exu_div
    import muldiv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_data_t dividend_i,   // rs1
    input  reg_data_t divisor_i,    // rs2
    input  logic      start_i,      // held high for the whole operation
    input  div_op_t   op_i,
    input  reg_addr_t reg_waddr_i,
    output reg_data_t result_o,
    output logic      ready_o,      // one-cycle pulse
    output logic      busy_o,
    output reg_addr_t reg_waddr_o
);

    div_state_t  state;
    div_state_t  state_nxt;
    logic [4:0]  count;
    div_op_t     op_r;
    reg_data_t   dividend_r;     // kept for the special results
    reg_data_t   divisor_abs_r;
    reg_data_t   rem_r;
    reg_data_t   quo_r;          // holds the dividend, shifts into quotient
    reg_addr_t   reg_waddr_r;
    logic        neg_q_r;
    logic        neg_r_r;
    logic        div_zero_r;
    logic        ovf_r;

    logic        is_signed;
    logic        div_zero;
    logic        ovf;
    reg_data_t   dividend_abs;
    reg_data_t   divisor_abs;
    logic [32:0] rem_shift;
    logic [32:0] rem_diff;
    reg_data_t   quo_fin;
    reg_data_t   rem_fin;

    assign is_signed = (op_i == DIV_S) || (op_i == REM_S);
    assign div_zero  = (divisor_i == '0);
    assign ovf       = is_signed && (dividend_i == 32'h8000_0000) && (divisor_i == '1);

    // min value maps onto itself, which is right as unsigned
    assign dividend_abs = (is_signed && dividend_i[31]) ? -dividend_i : dividend_i;
    assign divisor_abs  = (is_signed && divisor_i[31]) ? -divisor_i : divisor_i;

    assign rem_shift = {rem_r, quo_r[31]};
    assign rem_diff  = rem_shift - {1'b0, divisor_abs_r};  // bit 32 set means restore

    always_comb begin
        if (div_zero_r) begin
            quo_fin = '1;
            rem_fin = dividend_r;
        end else if (ovf_r) begin
            quo_fin = dividend_r;
            rem_fin = '0;
        end else begin
            quo_fin = neg_q_r ? -quo_r : quo_r;
            rem_fin = neg_r_r ? -rem_r : rem_r;
        end
    end

    always_comb begin
        case (state)
            D_IDLE:   state_nxt = (div_zero || ovf) ? D_OUTPUT : D_CALC;
            D_CALC:   state_nxt = (count == 5'd31) ? D_OUTPUT : D_CALC;
            D_OUTPUT: state_nxt = D_IDLE;
            default:  state_nxt = D_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= D_IDLE;
        end else if (!start_i) begin
            state <= D_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ready_o <= 1'b0;
            busy_o  <= 1'b0;
            count   <= '0;
        end else if (!start_i) begin
            ready_o <= 1'b0;  // abort, no result
            busy_o  <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    ready_o <= 1'b0;
                    busy_o  <= 1'b1;
                    count   <= '0;
                end
                D_CALC: count <= count + 5'd1;
                D_OUTPUT: begin
                    ready_o <= 1'b1;
                    busy_o  <= 1'b0;
                end
                default: ready_o <= 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            case (state)
                D_IDLE: begin
                    op_r          <= op_i;
                    reg_waddr_r   <= reg_waddr_i;
                    dividend_r    <= dividend_i;
                    divisor_abs_r <= divisor_abs;
                    rem_r         <= '0;
                    quo_r         <= dividend_abs;
                    neg_q_r       <= is_signed && (dividend_i[31] ^ divisor_i[31]);
                    neg_r_r       <= is_signed && dividend_i[31];  // remainder follows dividend
                    div_zero_r    <= div_zero;
                    ovf_r         <= ovf;
                end
                D_CALC: begin
                    if (rem_diff[32]) begin
                        rem_r <= rem_shift[31:0];
                        quo_r <= {quo_r[30:0], 1'b0};
                    end else begin
                        rem_r <= rem_diff[31:0];
                        quo_r <= {quo_r[30:0], 1'b1};
                    end
                end
                D_OUTPUT: begin
                    result_o    <= ((op_r == REM_S) || (op_r == REM_U)) ? rem_fin : quo_fin;
                    reg_waddr_o <= reg_waddr_r;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/exu_muldiv.sv
`timescale 1ns/1ns
// multiply/divide wrapper: funct3 decode, start steering, write-back merge

module exu_muldiv
    import muldiv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    start_i,
    input  md_req_t req_i,
    output logic    busy_o,
    output logic    done_o,
    output md_wb_t  wb_o
);

    logic      sel_div;     // funct3 bit 2
    mul_op_t   mul_op;
    div_op_t   div_op;
    logic      mul_start;
    logic      div_start;

    reg_data_t mul_result;
    logic      mul_ready;
    logic      mul_busy;
    reg_addr_t mul_waddr;

    reg_data_t div_result;
    logic      div_ready;
    logic      div_busy;
    reg_addr_t div_waddr;

    assign sel_div = req_i.funct3[FUNCT3_DIV_BIT];

    // low two funct3 bits line up with both op encodings
    assign mul_op = mul_op_t'(req_i.funct3[1:0]);
    assign div_op = div_op_t'(req_i.funct3[1:0]);

    assign mul_start = start_i && !sel_div;
    assign div_start = start_i && sel_div;  // unselected unit stays idle

    exu_mul u_mul (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .multiplicand_i (req_i.rs1),
        .multiplier_i   (req_i.rs2),
        .start_i        (mul_start),
        .op_i           (mul_op),
        .reg_waddr_i    (req_i.rd),
        .result_o       (mul_result),
        .ready_o        (mul_ready),
        .busy_o         (mul_busy),
        .reg_waddr_o    (mul_waddr)
    );

    exu_div u_div (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dividend_i  (req_i.rs1),
        .divisor_i   (req_i.rs2),
        .start_i     (div_start),
        .op_i        (div_op),
        .reg_waddr_i (req_i.rd),
        .result_o    (div_result),
        .ready_o     (div_ready),
        .busy_o      (div_busy),
        .reg_waddr_o (div_waddr)
    );

    assign done_o = mul_ready || div_ready;
    assign busy_o = mul_busy || div_busy;

    // zero between results
    always_comb begin
        if (div_ready) begin
            wb_o.data = div_result;
            wb_o.rd   = div_waddr;
        end else if (mul_ready) begin
            wb_o.data = mul_result;
            wb_o.rd   = mul_waddr;
        end else begin
            wb_o = '0;
        end
    end

endmodule

//--- verification/muldiv_assertions.sv
`timescale 1ns/1ns
// concurrent protocol assertions for exu_muldiv, attached by bind

module muldiv_assertions (
    input logic clk,
    input logic rst_n_i,
    input logic start_i,
    input logic done_i,
    input logic busy_i,
    input logic mul_busy_i,
    input logic div_busy_i
);

    int fail_count = 0;  // read by the testbench top

    // result is a single-cycle pulse
    done_single: assert property (@(posedge clk) disable iff (!rst_n_i) done_i |=> !done_i)
        else begin
            $error("done_o stayed high for two cycles in a row");
            fail_count++;
        end

    busy_after_done: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i ##1 !start_i |-> !busy_i)
        else begin
            $error("busy_o still high in the idle cycle after done_o");
            fail_count++;
        end

    // only the selected unit may run
    one_unit_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mul_busy_i && div_busy_i))
        else begin
            $error("multiplier and divider both busy at once");
            fail_count++;
        end

endmodule

//--- verification/muldiv_checker.sv
`timescale 1ns/1ns
// reference model and result checker for exu_muldiv
// samples the DUT ports on the falling edge and counts mismatches

module muldiv_checker
    import muldiv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    start_i,
    input  md_req_t req_i,
    input  logic    busy_i,
    input  logic    done_i,
    input  md_wb_t  wb_i,
    output int      err_count_o,
    output int      result_count_o
);

    md_req_t req_r;
    logic    active = 1'b0;      // request in flight
    logic    start_prev = 1'b0;
    int      lat = 0;            // edges since the start edge
    int      err_count = 0;
    int      result_count = 0;
    reg_data_t exp_data;

    assign err_count_o    = err_count;
    assign result_count_o = result_count;

    function automatic reg_data_t model_result(md_req_t r);
        logic signed [63:0] a_s;
        logic signed [63:0] b_s;
        logic [63:0]        a_u;
        logic [63:0]        b_u;
        logic signed [63:0] quo_s;
        logic signed [63:0] rem_s;
        logic [63:0]        quo_u;
        logic [63:0]        rem_u;
        logic [63:0]        res;
        a_s = {{32{r.rs1[31]}}, r.rs1};
        b_s = {{32{r.rs2[31]}}, r.rs2};
        a_u = {32'b0, r.rs1};
        b_u = {32'b0, r.rs2};
        // 64-bit math already gives the min / -1 overflow result
        quo_s = a_s / b_s;
        rem_s = a_s % b_s;
        quo_u = a_u / b_u;
        rem_u = a_u % b_u;
        case (r.funct3)
            3'd0, 3'd1: res = a_s * b_s;
            3'd2:       res = a_s * b_u;  // rs1 signed, rs2 unsigned
            3'd3:       res = a_u * b_u;
            3'd4:       res = (r.rs2 == '0) ? '1 : quo_s;
            3'd5:       res = (r.rs2 == '0) ? '1 : quo_u;
            3'd6:       res = (r.rs2 == '0) ? a_u : rem_s;
            default:    res = (r.rs2 == '0) ? a_u : rem_u;
        endcase
        if (r.funct3 inside {3'd1, 3'd2, 3'd3}) return res[63:32];
        return res[31:0];
    endfunction

    // edges from start to done
    function automatic int model_latency(md_req_t r);
        if (!r.funct3[2]) return 18;
        if (r.rs2 == '0) return 2;
        if ((r.funct3 == 3'd4 || r.funct3 == 3'd6) && r.rs1 == 32'h8000_0000 && r.rs2 == '1)
            return 2;
        return 34;
    endfunction

    always @(negedge clk) begin
        if (!rst_n_i) begin
            active     = 1'b0;
            start_prev = 1'b0;
            lat        = 0;
        end else begin
            if (active) begin
                lat = lat + 1;
                if (done_i) begin
                    result_count++;
                    exp_data = model_result(req_r);
                    if (wb_i.data !== exp_data) begin
                        $display("ERROR %0t ns: wb_o.data = %h, expected %h",
                                 $time, wb_i.data, exp_data);
                        $display("  funct3 %0d, rs1 %h, rs2 %h",
                                 req_r.funct3, req_r.rs1, req_r.rs2);
                        err_count++;
                    end
                    if (wb_i.rd !== req_r.rd) begin
                        $display("ERROR %0t ns: wb_o.rd = %0d, expected %0d",
                                 $time, wb_i.rd, req_r.rd);
                        err_count++;
                    end
                    if (lat != model_latency(req_r)) begin
                        $display("ERROR %0t ns: done_o latency = %0d, expected %0d",
                                 $time, lat, model_latency(req_r));
                        err_count++;
                    end
                    active = 1'b0;
                end else if (!start_i) begin
                    active = 1'b0;  // aborted
                end else if (busy_i !== 1'b1) begin
                    $display("ERROR %0t ns: busy_o = %b, expected 1", $time, busy_i);
                    err_count++;
                end
            end else if (done_i) begin
                $display("ERROR %0t ns: done_o = %b, expected 0 with no request in flight",
                         $time, done_i);
                err_count++;
            end
            if (!done_i && wb_i !== '0) begin
                $display("ERROR %0t ns: wb_o = %h, expected 0", $time, wb_i);
                err_count++;
            end
            if (!start_i && !start_prev && !active && busy_i !== 1'b0) begin
                $display("ERROR %0t ns: busy_o = %b, expected 0", $time, busy_i);
                err_count++;
            end
            if (start_i && !start_prev) begin
                req_r  = req_i;
                active = 1'b1;
                lat    = 0;
            end
            start_prev = start_i;
        end
    end

endmodule

//--- verification/tb_muldiv.sv
`timescale 1ns/1ns
// testbench top for the rv32m multiply/divide unit
// clock, reset, lcg stimulus, request sequence, timeout and summary

module tb_muldiv
    import muldiv_pkg::*;
();

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_REQ        = 400;
    localparam int NUM_DIRECTED   = 8;
    localparam int MAX_REQ_CYCLES = 40;  // longest divide plus gap
    localparam int TIMEOUT_CYCLES = NUM_REQ * MAX_REQ_CYCLES + RESET_CYCLES + 100;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    start;
    md_req_t req;
    logic    busy;
    logic    done;
    md_wb_t  wb;

    logic [31:0] lcg_state = 32'd99282;
    int cycle_count = 0;
    int completed = 0;
    int aborted = 0;
    int tb_errors = 0;
    int chk_errors;
    int chk_results;

    always #(CLK_PERIOD / 2) clk = ~clk;

    exu_muldiv u_dut (
        .clk     (clk),
        .rst_n_i (rst_n),
        .start_i (start),
        .req_i   (req),
        .busy_o  (busy),
        .done_o  (done),
        .wb_o    (wb)
    );

    muldiv_checker u_chk (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .start_i        (start),
        .req_i          (req),
        .busy_i         (busy),
        .done_i         (done),
        .wb_i           (wb),
        .err_count_o    (chk_errors),
        .result_count_o (chk_results)
    );

    bind exu_muldiv muldiv_assertions u_assert (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (start_i),
        .done_i     (done_o),
        .busy_i     (busy_o),
        .mul_busy_i (mul_busy),
        .div_busy_i (div_busy)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // upper bits only since the low ones cycle fast
    function automatic int rand_below(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:16]) % n;
    endfunction

    function automatic reg_data_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    // one draw in eight is a corner value
    function automatic reg_data_t pick_operand();
        if (rand_below(8) != 0) return rand_word();
        case (rand_below(4))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            default: return 32'h7fff_ffff;
        endcase
    endfunction

    // fields are funct3, rs1, rs2 and rd
    function automatic md_req_t directed_request(int idx);
        case (idx)
            0:       return {3'd4, 32'h8000_0000, 32'hffff_ffff, 5'd1};  // div overflow
            1:       return {3'd6, 32'h8000_0000, 32'hffff_ffff, 5'd2};  // rem overflow
            2:       return {3'd4, 32'h1234_5678, 32'h0000_0000, 5'd3};  // div by zero
            3:       return {3'd7, 32'hdead_beef, 32'h0000_0000, 5'd4};
            4:       return {3'd5, 32'h8000_0000, 32'hffff_ffff, 5'd5};
            5:       return {3'd3, 32'hffff_ffff, 32'hffff_ffff, 5'd6};
            6:       return {3'd2, 32'h8000_0000, 32'hffff_ffff, 5'd7};
            default: return {3'd1, 32'h8000_0000, 32'h8000_0000, 5'd8};
        endcase
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // holds start until done, or drops it early for an abort
    task automatic run_request(input md_req_t r, input bit abort, input int abort_after);
        int cycles;
        bit seen;
        cycles = 0;
        seen   = 1'b0;
        req    = r;
        start  = 1'b1;
        while (!seen && !(abort && cycles >= abort_after)) begin
            @(posedge clk);
            #1;
            cycles++;
            if (done) seen = 1'b1;
        end
        start = 1'b0;
        if (seen) completed++;
        else aborted++;
        idle_cycles(1);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a request never completed", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        md_req_t r;
        bit      abort;
        int      abort_after;
        int      total;
        rst_n = 1'b0;
        start = 1'b0;
        req   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle_cycles(4);  // outputs must stay quiet
        for (int i = 0; i < NUM_REQ; i++) begin
            if (i < NUM_DIRECTED) begin
                r           = directed_request(i);
                abort       = 1'b0;
                abort_after = 0;
            end else begin
                r.funct3    = md_funct3_t'(rand_below(8));
                r.rs1       = pick_operand();
                r.rs2       = pick_operand();
                r.rd        = reg_addr_t'(rand_below(32));
                abort       = (rand_below(10) == 0);
                abort_after = 1 + rand_below(16);
            end
            run_request(r, abort, abort_after);
            idle_cycles(rand_below(3));
        end
        idle_cycles(4);
        if (chk_results != completed) begin
            $display("checker saw %0d results but %0d requests completed",
                     chk_results, completed);
            tb_errors++;
        end
        total = chk_errors + tb_errors + u_dut.u_assert.fail_count;
        $write("errors %0d (checker %0d, assertions %0d, tb %0d), ",
               total, chk_errors, u_dut.u_assert.fail_count, tb_errors);
        $display("requests %0d, done %0d, aborted %0d", NUM_REQ, completed, aborted);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/muldiv_pkg.sv
verilog/exu_mul.sv
verilog/exu_div.sv
verilog/exu_muldiv.sv
verification/muldiv_assertions.sv
verification/muldiv_checker.sv
verification/tb_muldiv.sv

//--- Bender.yml
package:
  name: muldiv

sources:
  # RTL, package first
  - files:
      - verilog/muldiv_pkg.sv
      - verilog/exu_mul.sv
      - verilog/exu_div.sv
      - verilog/exu_muldiv.sv

  # testbench, top is tb_muldiv
  - target: test
    files:
      - verification/muldiv_assertions.sv
      - verification/muldiv_checker.sv
      - verification/tb_muldiv.sv
